//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_noc_mesh
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= No errors

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the result is decided by the pass line in the simulator output
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- include/noc_macros.svh
`ifndef NOC_MACROS_SVH
`define NOC_MACROS_SVH

// mesh dimensions, columns by rows
`define MESH_X    2
`define MESH_Y    2
`define COORD_W   2

`define FLIT_W    32
// input slots per port, also the reset credit count
`define BUF_DEPTH 4
`define CRD_W     3
`define PORT_NUM  5

`endif

//--- sim.f
+incdir+include
verilog/noc_flit_pkg.sv
verilog/noc_port_pkg.sv
verilog/noc_input_buffer.sv
verilog/noc_route_alloc.sv
verilog/noc_output_port.sv
verilog/noc_router.sv
verilog/noc_mesh_top.sv
sim/tb_noc_mesh.sv

//--- sim/noc_stimulus.txt
# src dst payload gap
# node = y*2 + x, payload is 24-bit hex, gap is idle cycles before injection
0 3 a00001 0
1 3 a00002 0
2 3 a00003 0
0 3 a00004 1
1 3 a00005 0
2 3 a00006 1
0 3 a00007 0
1 2 b00001 2
2 1 b00002 0
3 0 b00003 0
0 1 b00004 3
3 2 b00005 1
1 0 b00006 0
2 3 a00008 2
0 2 b00007 1
3 1 b00008 0
1 3 a00009 4
2 0 b00009 2

//--- sim/tb_noc_mesh.sv
`timescale 1ns/1ps
`include "noc_macros.svh"

module tb_noc_mesh
  import noc_flit_pkg::*;
();

  localparam int NODE_NUM   = `MESH_X * `MESH_Y;
  localparam int PAY_W      = `FLIT_W - 4 * `COORD_W;
  localparam int HOLD_NODE  = 3;
  localparam int HOLD_START = 6;
  localparam int HOLD_END   = 86;

  logic                 clk;
  logic                 rst_n_i;
  logic  [NODE_NUM-1:0] rx_flit_v;
  flit_t [NODE_NUM-1:0] rx_flit;
  logic  [NODE_NUM-1:0] rx_lcrd_v;
  logic  [NODE_NUM-1:0] tx_flit_v;
  flit_t [NODE_NUM-1:0] tx_flit;
  logic  [NODE_NUM-1:0] tx_lcrd_v;

  // injection queues per source and expected words per destination
  logic [`FLIT_W-1:0] inj_q [NODE_NUM][$];
  int                 gap_q [NODE_NUM][$];
  logic [`FLIT_W-1:0] exp_q [NODE_NUM][$];
  int inj_crd   [NODE_NUM];
  int wait_left [NODE_NUM];
  int inj_cnt   [NODE_NUM];
  int lcrd_seen [NODE_NUM];
  int pend_crd  [NODE_NUM];
  int total_flits = 0;
  int delivered   = 0;
  int hold_deliv  = 0;
  int run_cycle   = 0;
  int cycle_cnt   = 0;
  int cycle_limit = 0;

  noc_mesh_top u_dut (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .rx_flit_v_i (rx_flit_v),
    .rx_flit_i   (rx_flit),
    .rx_lcrd_v_o (rx_lcrd_v),
    .tx_flit_v_o (tx_flit_v),
    .tx_flit_o   (tx_flit),
    .tx_lcrd_v_i (tx_lcrd_v)
  );

  always #5 clk = ~clk;

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Errors found");
    $fatal(1, "run stopped");
  endtask

  task automatic report_mismatch(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    $display("Errors found");
    $fatal(1, "run stopped at first error");
  endtask

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
      abort_run($sformatf("timeout: traffic did not drain within %0d cycles", cycle_limit));
    end
  end

  // raw word in head view order with the destination on top
  function automatic logic [`FLIT_W-1:0] make_word(input int src, input int dst,
                                                   input logic [PAY_W-1:0] pay);
    logic [`COORD_W-1:0] dx;
    logic [`COORD_W-1:0] dy;
    logic [`COORD_W-1:0] sx;
    logic [`COORD_W-1:0] sy;
    dx = `COORD_W'(dst % `MESH_X);
    dy = `COORD_W'(dst / `MESH_X);
    sx = `COORD_W'(src % `MESH_X);
    sy = `COORD_W'(src / `MESH_X);
    return {dx, dy, sx, sy, pay};
  endfunction

  task automatic load_stimulus();
    int               fd;
    int               n_read;
    int               src;
    int               dst;
    int               gap;
    logic [PAY_W-1:0] pay;
    string            line;
    fd = $fopen("sim/noc_stimulus.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open the stimulus file sim/noc_stimulus.txt");
    end else begin
      // comment and blank lines do not scan as four fields
      while ($fgets(line, fd) != 0) begin
        n_read = $sscanf(line, "%d %d %h %d", src, dst, pay, gap);
        if (n_read == 4) begin
          if (src < 0 || src >= NODE_NUM || dst < 0 || dst >= NODE_NUM || src == dst) begin
            abort_run($sformatf("bad stimulus line with source %0d and destination %0d",
                                src, dst));
          end else begin
            inj_q[src].push_back(make_word(src, dst, pay));
            gap_q[src].push_back(gap);
            exp_q[dst].push_back(make_word(src, dst, pay));
            total_flits++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic check_idle();
    assert (tx_flit_v == '0 && rx_lcrd_v == '0)
      else report_mismatch("flit or credit strobe active around reset");
  endtask

  // the first pending entry from the same source must match so order is checked too
  task automatic check_delivery(input int node, input logic [`FLIT_W-1:0] word);
    int idx;
    idx = -1;
    for (int i = 0; i < exp_q[node].size(); i++) begin
      if (idx < 0 && exp_q[node][i][PAY_W +: 2*`COORD_W] == word[PAY_W +: 2*`COORD_W])
        idx = i;
    end
    assert (idx >= 0)
      else report_mismatch($sformatf("node %0d got unexpected flit %08h", node, word));
    assert (exp_q[node][idx] == word)
      else report_mismatch($sformatf("node %0d got %08h, expected %08h", node, word,
                                     exp_q[node][idx]));
    exp_q[node].delete(idx);
  endtask

  task automatic step_devices(input int cyc);
    bit holding;
    holding = (cyc >= HOLD_START && cyc < HOLD_END);
    for (int n = 0; n < NODE_NUM; n++) begin
      if (tx_flit_v[n]) begin
        check_delivery(n, tx_flit[n].raw);
        delivered++;
        pend_crd[n]++;
        if (holding && n == HOLD_NODE) hold_deliv++;
      end
      assert (hold_deliv <= `BUF_DEPTH)
        else report_mismatch($sformatf("node %0d took %0d flits with credits withheld",
                                       HOLD_NODE, hold_deliv));
      // one credit back per received flit but none during the hold
      if (pend_crd[n] > 0 && !(holding && n == HOLD_NODE)) begin
        tx_lcrd_v[n] = 1'b1;
        pend_crd[n]--;
      end else begin
        tx_lcrd_v[n] = 1'b0;
      end
      if (rx_lcrd_v[n]) begin
        inj_crd[n]++;
        lcrd_seen[n]++;
      end
      assert (inj_crd[n] <= `BUF_DEPTH)
        else report_mismatch($sformatf("node %0d injection credits at %0d", n, inj_crd[n]));
      rx_flit_v[n] = 1'b0;
      if (inj_q[n].size() > 0) begin
        if (wait_left[n] < 0) wait_left[n] = gap_q[n][0] + int'($urandom % 3);
        if (wait_left[n] > 0) begin
          wait_left[n]--;
        end else if (inj_crd[n] > 0) begin
          rx_flit[n].raw = inj_q[n].pop_front();
          void'(gap_q[n].pop_front());
          rx_flit_v[n] = 1'b1;
          inj_crd[n]--;
          inj_cnt[n]++;
          wait_left[n] = -1;
        end
      end
    end
  endtask

  function automatic bit traffic_drained();
    bit done;
    done = (delivered == total_flits);
    for (int n = 0; n < NODE_NUM; n++) begin
      if (inj_q[n].size() != 0 || pend_crd[n] != 0) done = 1'b0;
    end
    return done;
  endfunction

  initial begin
    void'($urandom(39));
    clk       = 1'b0;
    rst_n_i   = 1'b0;
    rx_flit_v = '0;
    rx_flit   = '0;
    tx_lcrd_v = '0;
    for (int n = 0; n < NODE_NUM; n++) begin
      inj_crd[n]   = `BUF_DEPTH;
      wait_left[n] = -1;
      inj_cnt[n]   = 0;
      lcrd_seen[n] = 0;
      pend_crd[n]  = 0;
    end
    load_stimulus();
    if (total_flits == 0) abort_run("the stimulus file holds no flits");
    cycle_limit = 64 * total_flits + 500;

    repeat (8) begin
      @(posedge clk);
      #1;
      check_idle();
    end
    rst_n_i = 1'b1;
    @(posedge clk);
    #1;
    check_idle();

    while (!traffic_drained()) begin
      step_devices(run_cycle);
      @(posedge clk);
      #1;
      run_cycle++;
    end

    for (int n = 0; n < NODE_NUM; n++) begin
      assert (lcrd_seen[n] == inj_cnt[n])
        else report_mismatch($sformatf("node %0d returned %0d credits for %0d flits", n,
                                       lcrd_seen[n], inj_cnt[n]));
    end
    $display("No errors");
    $finish;
  end

endmodule

//--- verilog/noc_flit_pkg.sv
`include "noc_macros.svh"

package noc_flit_pkg;

  // routing fields sit at the top of the word
  typedef struct packed {
    logic [`COORD_W-1:0]            dest_x;
    logic [`COORD_W-1:0]            dest_y;
    logic [`COORD_W-1:0]            src_x;
    logic [`COORD_W-1:0]            src_y;
    logic [`FLIT_W-4*`COORD_W-1:0]  payload;
  } flit_head_t;

  // routers decode the head view, devices only see the raw word
  typedef union packed {
    flit_head_t          head;
    logic [`FLIT_W-1:0]  raw;
  } flit_t;

endpackage

//--- verilog/noc_input_buffer.sv
`timescale 1ns/1ps
`include "noc_macros.svh"

module noc_input_buffer
  import noc_flit_pkg::*;
  import noc_port_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n_i,
  input  logic      push_v_i,
  input  flit_t     push_flit_i,
  input  io_port_t  push_route_i,
  input  logic      pop_i,
  output logic      head_v_o,
  output flit_t     head_flit_o,
  output io_port_t  head_route_o,
  output logic      crd_v_o
);

  localparam int PTR_W = $clog2(`BUF_DEPTH);

  flit_t              flit_mem  [`BUF_DEPTH];
  io_port_t           route_mem [`BUF_DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [`CRD_W-1:0]  count;
  logic               do_pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(`BUF_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign head_v_o     = (count != '0);
  assign head_flit_o  = flit_mem[rd_ptr];
  assign head_route_o = route_mem[rd_ptr];
  assign do_pop       = pop_i && head_v_o;

  always_ff @(posedge clk) begin
    if (push_v_i) begin
      flit_mem[wr_ptr]  <= push_flit_i;
      route_mem[wr_ptr] <= push_route_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      crd_v_o <= 1'b0;
    end else begin
      // one slot freed, one credit back upstream next cycle
      crd_v_o <= do_pop;
      if (push_v_i) wr_ptr <= ptr_inc(wr_ptr);
      if (do_pop) rd_ptr <= ptr_inc(rd_ptr);
      case ({push_v_i, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

endmodule

//--- verilog/noc_mesh_top.sv
`timescale 1ns/1ps
`include "noc_macros.svh"

module noc_mesh_top
  import noc_flit_pkg::*;
  import noc_port_pkg::*;
(
  input  logic                               clk,
  input  logic                               rst_n_i,
  input  logic  [`MESH_X*`MESH_Y-1:0]  rx_flit_v_i,
  input  flit_t [`MESH_X*`MESH_Y-1:0]  rx_flit_i,
  output logic  [`MESH_X*`MESH_Y-1:0]  rx_lcrd_v_o,
  output logic  [`MESH_X*`MESH_Y-1:0]  tx_flit_v_o,
  output flit_t [`MESH_X*`MESH_Y-1:0]  tx_flit_o,
  input  logic  [`MESH_X*`MESH_Y-1:0]  tx_lcrd_v_i
);

  localparam int NODE_NUM = `MESH_X * `MESH_Y;

  logic     [NODE_NUM-1:0][`PORT_NUM-1:0] rx_v;
  flit_t    [NODE_NUM-1:0][`PORT_NUM-1:0] rx_flit;
  io_port_t [NODE_NUM-1:0][`PORT_NUM-1:0] rx_route;
  logic     [NODE_NUM-1:0][`PORT_NUM-1:0] rx_crd;
  logic     [NODE_NUM-1:0][`PORT_NUM-1:0] tx_v;
  flit_t    [NODE_NUM-1:0][`PORT_NUM-1:0] tx_flit;
  io_port_t [NODE_NUM-1:0][`PORT_NUM-1:0] tx_route;
  logic     [NODE_NUM-1:0][`PORT_NUM-1:0] tx_crd;

  for (genvar y = 0; y < `MESH_Y; y++) begin : gen_y
    for (genvar x = 0; x < `MESH_X; x++) begin : gen_x
      localparam int NID = y * `MESH_X + x;

      noc_router #(
        .NODE_X (x),
        .NODE_Y (y)
      ) u_router (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .rx_flit_v_i (rx_v[NID]),
        .rx_flit_i   (rx_flit[NID]),
        .rx_route_i  (rx_route[NID]),
        .rx_lcrd_v_o (rx_crd[NID]),
        .tx_flit_v_o (tx_v[NID]),
        .tx_flit_o   (tx_flit[NID]),
        .tx_route_o  (tx_route[NID]),
        .tx_lcrd_v_i (tx_crd[NID])
      );

      // N of (x,y) and S of (x,y+1), both directions
      if (y < `MESH_Y - 1) begin : gen_link_ns
        assign rx_v[NID+`MESH_X][S]     = tx_v[NID][N];
        assign rx_flit[NID+`MESH_X][S]  = tx_flit[NID][N];
        assign rx_route[NID+`MESH_X][S] = tx_route[NID][N];
        assign tx_crd[NID][N]           = rx_crd[NID+`MESH_X][S];
        assign rx_v[NID][N]             = tx_v[NID+`MESH_X][S];
        assign rx_flit[NID][N]          = tx_flit[NID+`MESH_X][S];
        assign rx_route[NID][N]         = tx_route[NID+`MESH_X][S];
        assign tx_crd[NID+`MESH_X][S]   = rx_crd[NID][N];
      end else begin : gen_edge_n
        assign rx_v[NID][N]     = 1'b0;
        assign rx_flit[NID][N]  = '0;
        assign rx_route[NID][N] = N;
        assign tx_crd[NID][N]   = 1'b0;
      end
      if (y == 0) begin : gen_edge_s
        assign rx_v[NID][S]     = 1'b0;
        assign rx_flit[NID][S]  = '0;
        assign rx_route[NID][S] = N;
        assign tx_crd[NID][S]   = 1'b0;
      end

      // E of (x,y) and W of (x+1,y), both directions
      if (x < `MESH_X - 1) begin : gen_link_ew
        assign rx_v[NID+1][W]     = tx_v[NID][E];
        assign rx_flit[NID+1][W]  = tx_flit[NID][E];
        assign rx_route[NID+1][W] = tx_route[NID][E];
        assign tx_crd[NID][E]     = rx_crd[NID+1][W];
        assign rx_v[NID][E]       = tx_v[NID+1][W];
        assign rx_flit[NID][E]    = tx_flit[NID+1][W];
        assign rx_route[NID][E]   = tx_route[NID+1][W];
        assign tx_crd[NID+1][W]   = rx_crd[NID][E];
      end else begin : gen_edge_e
        assign rx_v[NID][E]     = 1'b0;
        assign rx_flit[NID][E]  = '0;
        assign rx_route[NID][E] = N;
        assign tx_crd[NID][E]   = 1'b0;
      end
      if (x == 0) begin : gen_edge_w
        assign rx_v[NID][W]     = 1'b0;
        assign rx_flit[NID][W]  = '0;
        assign rx_route[NID][W] = N;
        assign tx_crd[NID][W]   = 1'b0;
      end

      // local device port, its route is worked out inside the router
      assign rx_v[NID][L]     = rx_flit_v_i[NID];
      assign rx_flit[NID][L]  = rx_flit_i[NID];
      assign rx_route[NID][L] = L;
      assign rx_lcrd_v_o[NID] = rx_crd[NID][L];
      assign tx_flit_v_o[NID] = tx_v[NID][L];
      assign tx_flit_o[NID]   = tx_flit[NID][L];
      assign tx_crd[NID][L]   = tx_lcrd_v_i[NID];
    end
  end

endmodule

//--- verilog/noc_output_port.sv
`timescale 1ns/1ps
`include "noc_macros.svh"

module noc_output_port
  import noc_flit_pkg::*;
  import noc_port_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n_i,
  input  logic      send_v_i,
  input  flit_t     send_flit_i,
  input  io_port_t  send_route_i,
  input  logic      crd_ret_i,
  output logic      crd_avail_o,
  output logic      tx_v_o,
  output flit_t     tx_flit_o,
  output io_port_t  tx_route_o
);

  // free slots in the downstream buffer
  logic [`CRD_W-1:0] crd_cnt;

  assign crd_avail_o = (crd_cnt != '0);

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      crd_cnt <= `CRD_W'(`BUF_DEPTH);
      tx_v_o  <= 1'b0;
    end else begin
      tx_v_o <= send_v_i;
      case ({send_v_i, crd_ret_i})
        2'b10:   crd_cnt <= crd_cnt - 1'b1;
        2'b01:   crd_cnt <= crd_cnt + 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (send_v_i) begin
      tx_flit_o  <= send_flit_i;
      tx_route_o <= send_route_i;
    end
  end

endmodule

//--- verilog/noc_port_pkg.sv
`include "noc_macros.svh"

package noc_port_pkg;

  // north is +y, east is +x
  typedef enum logic [2:0] {N = 3'd0, S = 3'd1, E = 3'd2, W = 3'd3, L = 3'd4} io_port_t;

  // dimension order, x first
  function automatic io_port_t xy_route(input logic [`COORD_W-1:0] cur_x,
                                        input logic [`COORD_W-1:0] cur_y,
                                        input logic [`COORD_W-1:0] dst_x,
                                        input logic [`COORD_W-1:0] dst_y);
    io_port_t port;
    if (dst_x > cur_x) port = E;
    else if (dst_x < cur_x) port = W;
    else if (dst_y > cur_y) port = N;
    else if (dst_y < cur_y) port = S;
    else port = L;
    return port;
  endfunction

endpackage

//--- verilog/noc_route_alloc.sv
`timescale 1ns/1ps
`include "noc_macros.svh"

module noc_route_alloc
  import noc_flit_pkg::*;
  import noc_port_pkg::*;
#(
  parameter int NODE_X = 0,
  parameter int NODE_Y = 0,
  localparam int PORT_W = $clog2(`PORT_NUM)
) (
  input  logic                              clk,
  input  logic                              rst_n_i,
  input  logic     [`PORT_NUM-1:0]              head_v_i,
  input  flit_t    [`PORT_NUM-1:0]              head_flit_i,
  input  io_port_t [`PORT_NUM-1:0]              head_route_i,
  input  logic     [`PORT_NUM-1:0]              crd_avail_i,
  output logic     [`PORT_NUM-1:0][PORT_W-1:0]  grant_o,
  output logic     [`PORT_NUM-1:0]              grant_v_o,
  output io_port_t [`PORT_NUM-1:0]              la_route_o
);

  localparam logic [`COORD_W-1:0] CUR_X = NODE_X[`COORD_W-1:0];
  localparam logic [`COORD_W-1:0] CUR_Y = NODE_Y[`COORD_W-1:0];

  // per output, the input index that has priority
  logic [`PORT_NUM-1:0][PORT_W-1:0] rr_ptr;

  always_comb begin : comb_arb
    int idx;
    for (int o = 0; o < `PORT_NUM; o++) begin
      grant_v_o[o] = 1'b0;
      grant_o[o]   = '0;
      for (int k = 0; k < `PORT_NUM; k++) begin
        idx = int'(rr_ptr[o]) + k;
        if (idx >= `PORT_NUM) idx = idx - `PORT_NUM;
        if (!grant_v_o[o] && crd_avail_i[o] && head_v_i[idx] &&
            head_route_i[idx] == io_port_t'(o)) begin
          grant_v_o[o] = 1'b1;
          grant_o[o]   = PORT_W'(idx);
        end
      end
    end
  end

  // route at the neighbour behind each output port
  always_comb begin : comb_la
    flit_t               win;
    logic [`COORD_W-1:0] nxt_x;
    logic [`COORD_W-1:0] nxt_y;
    for (int o = 0; o < `PORT_NUM; o++) begin
      win   = head_flit_i[grant_o[o]];
      nxt_x = CUR_X;
      nxt_y = CUR_Y;
      case (io_port_t'(o))
        N:       nxt_y = CUR_Y + 1'b1;
        S:       nxt_y = CUR_Y - 1'b1;
        E:       nxt_x = CUR_X + 1'b1;
        W:       nxt_x = CUR_X - 1'b1;
        default: ;
      endcase
      // the local output keeps this node, which resolves to L
      la_route_o[o] = xy_route(nxt_x, nxt_y, win.head.dest_x, win.head.dest_y);
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rr_ptr <= '0;
    end else begin
      for (int o = 0; o < `PORT_NUM; o++) begin
        if (grant_v_o[o]) begin
          rr_ptr[o] <= (grant_o[o] == PORT_W'(`PORT_NUM - 1)) ? '0 : grant_o[o] + 1'b1;
        end
      end
    end
  end

endmodule

//--- verilog/noc_router.sv
`timescale 1ns/1ps
`include "noc_macros.svh"

module noc_router
  import noc_flit_pkg::*;
  import noc_port_pkg::*;
#(
  parameter int NODE_X = 0,
  parameter int NODE_Y = 0
) (
  input  logic                      clk,
  input  logic                      rst_n_i,
  input  logic     [`PORT_NUM-1:0]  rx_flit_v_i,
  input  flit_t    [`PORT_NUM-1:0]  rx_flit_i,
  input  io_port_t [`PORT_NUM-1:0]  rx_route_i,
  output logic     [`PORT_NUM-1:0]  rx_lcrd_v_o,
  output logic     [`PORT_NUM-1:0]  tx_flit_v_o,
  output flit_t    [`PORT_NUM-1:0]  tx_flit_o,
  output io_port_t [`PORT_NUM-1:0]  tx_route_o,
  input  logic     [`PORT_NUM-1:0]  tx_lcrd_v_i
);

  localparam int PORT_W = $clog2(`PORT_NUM);
  localparam logic [`COORD_W-1:0] CUR_X = NODE_X[`COORD_W-1:0];
  localparam logic [`COORD_W-1:0] CUR_Y = NODE_Y[`COORD_W-1:0];

  logic     [`PORT_NUM-1:0]              head_v;
  flit_t    [`PORT_NUM-1:0]              head_flit;
  io_port_t [`PORT_NUM-1:0]              head_route;
  io_port_t [`PORT_NUM-1:0]              push_route;
  logic     [`PORT_NUM-1:0]              pop;
  logic     [`PORT_NUM-1:0]              crd_avail;
  logic     [`PORT_NUM-1:0][PORT_W-1:0]  grant;
  logic     [`PORT_NUM-1:0]              grant_v;
  io_port_t [`PORT_NUM-1:0]              la_route;
  flit_t    [`PORT_NUM-1:0]              send_flit;

  // crossbar: winning head to its output, and pop the winners
  always_comb begin
    pop = '0;
    for (int o = 0; o < `PORT_NUM; o++) begin
      send_flit[o] = head_flit[grant[o]];
      if (grant_v[o]) pop[grant[o]] = 1'b1;
    end
  end

  for (genvar p = 0; p < `PORT_NUM; p++) begin : gen_port
    if (io_port_t'(p) == L) begin : gen_local_route
      // devices send no look-ahead, route from the destination here
      assign push_route[p] = xy_route(CUR_X, CUR_Y, rx_flit_i[p].head.dest_x,
                                      rx_flit_i[p].head.dest_y);
    end else begin : gen_link_route
      assign push_route[p] = rx_route_i[p];
    end

    noc_input_buffer u_ibuf (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .push_v_i     (rx_flit_v_i[p]),
      .push_flit_i  (rx_flit_i[p]),
      .push_route_i (push_route[p]),
      .pop_i        (pop[p]),
      .head_v_o     (head_v[p]),
      .head_flit_o  (head_flit[p]),
      .head_route_o (head_route[p]),
      .crd_v_o      (rx_lcrd_v_o[p])
    );

    noc_output_port u_oport (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .send_v_i     (grant_v[p]),
      .send_flit_i  (send_flit[p]),
      .send_route_i (la_route[p]),
      .crd_ret_i    (tx_lcrd_v_i[p]),
      .crd_avail_o  (crd_avail[p]),
      .tx_v_o       (tx_flit_v_o[p]),
      .tx_flit_o    (tx_flit_o[p]),
      .tx_route_o   (tx_route_o[p])
    );
  end

  noc_route_alloc #(
    .NODE_X (NODE_X),
    .NODE_Y (NODE_Y)
  ) u_alloc (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .head_v_i     (head_v),
    .head_flit_i  (head_flit),
    .head_route_i (head_route),
    .crd_avail_i  (crd_avail),
    .grant_o      (grant),
    .grant_v_o    (grant_v),
    .la_route_o   (la_route)
  );

endmodule
